// ==== tb.f ====
+incdir+tests
src/llc_tag_pkg.sv
src/tag_way_ram.sv
src/victim_select.sv
src/tag_store_ctrl.sv
src/resp_skid_buffer.sv
src/tag_store.sv
tests/tb_tag_store.sv

// ==== run.sh ====
#!/bin/sh
# Compile the tag store testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module tb_tag_store -f tb.f \
  && ./obj_dir/Vtb_tag_store > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tests/tb_tag_model.svh ====
// Reference model of the tag array and victim pointer, predicts every response
`ifndef TB_TAG_MODEL_SVH
`define TB_TAG_MODEL_SVH

// Response fields as they appear on the res_* outputs
typedef struct packed {
  way_ind_t way;
  logic     hit;
  logic     evict;
  tag_t     tag;
} resp_t;

// Model copy of the tag array
logic m_valid [NumSets][NumWays];
logic m_dirty [NumSets][NumWays];
tag_t m_tag   [NumSets][NumWays];
// Model copy of the round-robin pointer
int   m_ptr;

// Empty array and pointer at zero, as after reset
function automatic void model_reset();
  for (int s = 0; s < NumSets; s++) begin
    for (int w = 0; w < NumWays; w++) begin
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
      m_tag[s][w]   = '0;
    end
  end
  m_ptr = 0;
endfunction

// Apply one accepted request to the model and return its expected response
function automatic resp_t model_apply(op_t op, index_t idx, tag_t tag, logic dirty,
                                      way_ind_t way, way_ind_t lock);
  resp_t    r;
  way_ind_t elig;
  int       vic;
  int       hit_w;
  r     = '0;
  vic   = -1;
  hit_w = -1;
  // Flush reads the named way, reports it and clears it
  if (op == OpFlush) begin
    r.way = way;
    for (int w = 0; w < NumWays; w++) begin
      if (way[w]) begin
        vic = w;
      end
    end
    if (vic >= 0) begin
      if (m_valid[idx][vic] && m_dirty[idx][vic]) begin
        r.evict = 1'b1;
        r.tag   = m_tag[idx][vic];
      end
      m_valid[idx][vic] = 1'b0;
      m_dirty[idx][vic] = 1'b0;
      m_tag[idx][vic]   = '0;
    end
    return r;
  end
  // Hit needs an enabled valid way with the same tag
  for (int w = 0; w < NumWays; w++) begin
    if (way[w] && m_valid[idx][w] && (m_tag[idx][w] == tag)) begin
      hit_w = w;
    end
  end
  if (hit_w >= 0) begin
    r.way[hit_w] = 1'b1;
    r.hit        = 1'b1;
    // A dirty request marks the line dirty
    if (dirty) begin
      m_dirty[idx][hit_w] = 1'b1;
    end
    return r;
  end
  // Miss, locked ways are not eligible
  elig = way & ~lock;
  // Lowest invalid eligible way first, the pointer stays
  for (int w = NumWays - 1; w >= 0; w--) begin
    if (elig[w] && !m_valid[idx][w]) begin
      vic = w;
    end
  end
  // Else first eligible way at or above the pointer, pointer moves past it
  if (vic < 0) begin
    for (int k = 0; k < NumWays; k++) begin
      if (vic < 0 && elig[(m_ptr + k) % NumWays]) begin
        vic = (m_ptr + k) % NumWays;
      end
    end
    if (vic >= 0) begin
      m_ptr = (vic + 1) % NumWays;
    end
  end
  // No eligible way, empty response and no write
  if (vic < 0) begin
    return r;
  end
  r.way[vic] = 1'b1;
  if (m_valid[idx][vic] && m_dirty[idx][vic]) begin
    r.evict = 1'b1;
    r.tag   = m_tag[idx][vic];
  end
  m_valid[idx][vic] = 1'b1;
  m_dirty[idx][vic] = dirty;
  m_tag[idx][vic]   = tag;
  return r;
endfunction

`endif

// ==== tests/tb_tag_store.sv ====
// Testbench for the LLC tag store with directed cases and a random mix under back-pressure
`timescale 1ns/1ps

module tb_tag_store;
  import llc_tag_pkg::*;

  `include "tb_tag_model.svh"

  localparam int unsigned RandOps   = 400;
  localparam int unsigned WaitLimit = 200;

  // DUT inputs
  logic     clk_i;
  logic     rst_i;
  way_ind_t spm_lock_i;
  op_t      req_op_i;
  index_t   req_index_i;
  tag_t     req_tag_i;
  logic     req_dirty_i;
  way_ind_t req_way_i;
  logic     req_valid_i;
  logic     res_ready_i;
  // DUT outputs
  logic     req_ready_o;
  way_ind_t res_way_o;
  logic     res_hit_o;
  logic     res_evict_o;
  tag_t     res_evict_tag_o;
  logic     res_valid_o;

  // Expected responses in request order
  resp_t       exp_q [$];
  int          errors;
  int          n_acc;
  int          n_rsp;
  logic [31:0] stim_state;
  logic [31:0] bp_state;
  logic        bp_en;
  // Six tags shared by four sets so that hits and evictions are frequent
  tag_t        tag_pool [6] = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66};

  tag_store i_tag_store (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .spm_lock_i      (spm_lock_i),
    .req_op_i        (req_op_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_way_i       (req_way_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .res_way_o       (res_way_o),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(string what);
    $display("Timeout while waiting for %s", what);
    $display("Finished with errors");
    $finish;
  endtask

  // Drive one request on the falling edge and hold it until accepted
  task automatic send_req(op_t op, index_t idx, tag_t tag, logic dirty, way_ind_t way,
                          output resp_t exp);
    int   cnt;
    logic done;
    cnt  = 0;
    done = 1'b0;
    exp  = '0;
    @(negedge clk_i);
    req_op_i    = op;
    req_index_i = idx;
    req_tag_i   = tag;
    req_dirty_i = dirty;
    req_way_i   = way;
    req_valid_i = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      if (req_ready_o) begin
        done = 1'b1;
        exp  = model_apply(op, idx, tag, dirty, way, spm_lock_i);
        exp_q.push_back(exp);
      end else begin
        cnt++;
        if (cnt > WaitLimit) abort_on_timeout("request acceptance");
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Wait until every expected response has come out
  task automatic wait_drain();
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > WaitLimit) abort_on_timeout("outstanding responses");
    end
  endtask

  // Random back-pressure with ready about two cycles in three
  always @(negedge clk_i) begin
    if (bp_en) begin
      bp_state    = xorshift32(bp_state);
      res_ready_i = (bp_state % 3 != 0);
    end else begin
      res_ready_i = 1'b1;
    end
  end

  // Compare every response hand-over with the front of the queue
  always @(posedge clk_i) begin : compare_resp
    resp_t e;
    if (!rst_i) begin
      // Controller idle means at most the two buffered responses are owed
      check_value("request ready while a response is owed",
                  32'(req_ready_o && (n_acc - n_rsp > 2)), 32'd0);
      if (n_acc == n_rsp) begin
        check_value("response valid with nothing owed", 32'(res_valid_o), 32'd0);
      end
      if (req_valid_i && req_ready_o) begin
        n_acc++;
      end
      if (res_valid_o && res_ready_i) begin
        n_rsp++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Response seen at %0t with no request waiting for it", $time);
        end else begin
          e = exp_q.pop_front();
          check_value("response way", 32'(res_way_o), 32'(e.way));
          check_value("response hit", 32'(res_hit_o), 32'(e.hit));
          check_value("response evict", 32'(res_evict_o), 32'(e.evict));
          check_value("response evict tag", 32'(res_evict_tag_o), 32'(e.tag));
        end
      end
    end
  end

  initial begin
    resp_t r;
    int    pick;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    spm_lock_i  = '0;
    req_op_i    = OpLookup;
    req_index_i = '0;
    req_tag_i   = '0;
    req_dirty_i = 1'b0;
    req_way_i   = '0;
    req_valid_i = 1'b0;
    res_ready_i = 1'b1;
    bp_en       <= 1'b0;
    errors      = 0;
    n_acc       = 0;
    n_rsp       = 0;
    stim_state  = 32'd29873;
    bp_state    = 32'd29873;
    model_reset();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_value("ready after reset", 32'(req_ready_o), 32'd1);
    check_value("valid after reset", 32'(res_valid_o), 32'd0);

    // Empty set misses into way 0 and the repeat hits way 0
    send_req(OpLookup, 4'd8, 8'h21, 1'b0, 4'hF, r);
    check_value("empty set miss way", 32'(r.way), 32'h1);
    check_value("empty set evict", 32'(r.evict), 32'd0);
    send_req(OpLookup, 4'd8, 8'h21, 1'b0, 4'hF, r);
    check_value("repeat lookup hit", 32'(r.hit), 32'd1);

    // Dirty hit marks the line and a full set then evicts it round robin
    send_req(OpLookup, 4'd9, 8'h31, 1'b0, 4'hF, r);
    send_req(OpLookup, 4'd9, 8'h31, 1'b1, 4'hF, r);
    send_req(OpLookup, 4'd9, 8'h32, 1'b0, 4'hF, r);
    send_req(OpLookup, 4'd9, 8'h33, 1'b0, 4'hF, r);
    send_req(OpLookup, 4'd9, 8'h34, 1'b0, 4'hF, r);
    send_req(OpLookup, 4'd9, 8'h35, 1'b1, 4'hF, r);
    check_value("dirty victim evict", 32'(r.evict), 32'd1);
    check_value("dirty victim tag", 32'(r.tag), 32'h31);
    send_req(OpLookup, 4'd9, 8'h36, 1'b0, 4'hF, r);
    check_value("next victim way", 32'(r.way), 32'h2);

    // Flush of dirty and clean ways and a miss on the flushed tag
    send_req(OpFlush, 4'd9, 8'h00, 1'b0, 4'b0001, r);
    check_value("dirty flush evict", 32'(r.evict), 32'd1);
    send_req(OpFlush, 4'd9, 8'h00, 1'b0, 4'b0010, r);
    check_value("clean flush evict", 32'(r.evict), 32'd0);
    send_req(OpLookup, 4'd9, 8'h35, 1'b0, 4'hF, r);
    check_value("lookup after flush hit", 32'(r.hit), 32'd0);

    // Ways 0 and 1 locked while nothing is in flight
    wait_drain();
    spm_lock_i = 4'b0011;
    for (int i = 0; i < 6; i++) begin
      send_req(OpLookup, 4'd10, tag_t'(8'h41 + (i % 5)), 1'b0, 4'hF, r);
      check_value("locked way used", 32'(r.way & 4'b0011), 32'd0);
    end
    wait_drain();
    spm_lock_i = 4'b0000;

    // Random mix under back-pressure
    bp_en <= 1'b1;
    for (int n = 0; n < RandOps; n++) begin
      stim_state = xorshift32(stim_state);
      pick       = int'(stim_state[15:8] % 8'd6);
      if (stim_state[1:0] == 2'd0) begin
        send_req(OpFlush, {2'b00, stim_state[5:4]}, 8'h00, 1'b0,
                 way_ind_t'(4'b0001 << stim_state[17:16]), r);
      end else begin
        send_req(OpLookup, {2'b00, stim_state[5:4]}, tag_pool[pick], stim_state[12],
                 4'hF, r);
      end
    end
    wait_drain();
    bp_en <= 1'b0;

    check_value("responses against requests", 32'(n_rsp), 32'(n_acc));
    $display("Errors: %0d, requests: %0d, responses: %0d", errors, n_acc, n_rsp);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== src/tag_store.sv ====
// LLC tag store top, ways plus controller, victim choice and response buffer
`timescale 1ns/1ps

module tag_store (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  llc_tag_pkg::way_ind_t   spm_lock_i,
  input  llc_tag_pkg::op_t        req_op_i,
  input  llc_tag_pkg::index_t     req_index_i,
  input  llc_tag_pkg::tag_t       req_tag_i,
  input  logic                    req_dirty_i,
  input  llc_tag_pkg::way_ind_t   req_way_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output llc_tag_pkg::way_ind_t   res_way_o,
  output logic                    res_hit_o,
  output logic                    res_evict_o,
  output llc_tag_pkg::tag_t       res_evict_tag_o,
  output logic                    res_valid_o,
  input  logic                    res_ready_i
);
  import llc_tag_pkg::*;

  // Way access
  way_ind_t                 ram_req;
  way_ind_t                 ram_we;
  index_t                   ram_index;
  tag_entry_t               ram_wdata;
  tag_entry_t [NumWays-1:0] ram_rdata;
  way_ind_t                 ram_rvalid;

  // Victim choice
  logic     victim_req;
  way_ind_t eligible;
  way_ind_t entry_valid;
  way_ind_t victim_way;

  // Controller to output buffer
  way_ind_t rsp_way;
  logic     rsp_hit;
  logic     rsp_evict;
  tag_t     rsp_evict_tag;
  logic     rsp_valid;
  logic     rsp_ready;

  for (genvar i = 0; i < NumWays; i++) begin : gen_ways
    tag_way_ram i_tag_way_ram (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (ram_req[i]),
      .we_i     (ram_we[i]),
      .index_i  (ram_index),
      .wdata_i  (ram_wdata),
      .rdata_o  (ram_rdata[i]),
      .rvalid_o (ram_rvalid[i])
    );
  end

  tag_store_ctrl i_tag_store_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_op_i        (req_op_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_way_i       (req_way_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .spm_lock_i      (spm_lock_i),
    .ram_req_o       (ram_req),
    .ram_we_o        (ram_we),
    .ram_index_o     (ram_index),
    .ram_wdata_o     (ram_wdata),
    .ram_rdata_i     (ram_rdata),
    .ram_rvalid_i    (ram_rvalid),
    .victim_req_o    (victim_req),
    .eligible_o      (eligible),
    .entry_valid_o   (entry_valid),
    .victim_way_i    (victim_way),
    .rsp_way_o       (rsp_way),
    .rsp_hit_o       (rsp_hit),
    .rsp_evict_o     (rsp_evict),
    .rsp_evict_tag_o (rsp_evict_tag),
    .rsp_valid_o     (rsp_valid),
    .rsp_ready_i     (rsp_ready)
  );

  victim_select i_victim_select (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (victim_req),
    .eligible_i (eligible),
    .valid_i    (entry_valid),
    .way_o      (victim_way)
  );

  resp_skid_buffer i_resp_skid_buffer (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .rsp_way_i       (rsp_way),
    .rsp_hit_i       (rsp_hit),
    .rsp_evict_i     (rsp_evict),
    .rsp_evict_tag_i (rsp_evict_tag),
    .valid_i         (rsp_valid),
    .ready_o         (rsp_ready),
    .res_way_o       (res_way_o),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o),
    .valid_o         (res_valid_o),
    .ready_i         (res_ready_i)
  );

endmodule

// ==== src/resp_skid_buffer.sv ====
// Two-entry response FIFO that decouples the response ready from the controller
`timescale 1ns/1ps

module resp_skid_buffer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  llc_tag_pkg::way_ind_t rsp_way_i,
  input  logic                  rsp_hit_i,
  input  logic                  rsp_evict_i,
  input  llc_tag_pkg::tag_t     rsp_evict_tag_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output llc_tag_pkg::way_ind_t res_way_o,
  output logic                  res_hit_o,
  output logic                  res_evict_o,
  output llc_tag_pkg::tag_t     res_evict_tag_o,
  output logic                  valid_o,
  input  logic                  ready_i
);
  import llc_tag_pkg::*;

  // Payload slots
  way_ind_t way_q   [2];
  logic     hit_q   [2];
  logic     evict_q [2];
  tag_t     tag_q   [2];

  // Pointers and fill level
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  // Head of the queue drives the outputs
  assign res_way_o       = way_q[rd_ptr_q];
  assign res_hit_o       = hit_q[rd_ptr_q];
  assign res_evict_o     = evict_q[rd_ptr_q];
  assign res_evict_tag_o = tag_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      way_q[wr_ptr_q]   <= rsp_way_i;
      hit_q[wr_ptr_q]   <= rsp_hit_i;
      evict_q[wr_ptr_q] <= rsp_evict_i;
      tag_q[wr_ptr_q]   <= rsp_evict_tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Level moves only when exactly one side transfers
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

endmodule

// ==== src/tag_store_ctrl.sv ====
// Tag store controller, runs lookups and flushes and forms responses and write-backs
`timescale 1ns/1ps

module tag_store_ctrl (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  input  llc_tag_pkg::op_t                                 req_op_i,
  input  llc_tag_pkg::index_t                              req_index_i,
  input  llc_tag_pkg::tag_t                                req_tag_i,
  input  logic                                             req_dirty_i,
  input  llc_tag_pkg::way_ind_t                            req_way_i,
  input  logic                                             req_valid_i,
  output logic                                             req_ready_o,
  input  llc_tag_pkg::way_ind_t                            spm_lock_i,
  output llc_tag_pkg::way_ind_t                            ram_req_o,
  output llc_tag_pkg::way_ind_t                            ram_we_o,
  output llc_tag_pkg::index_t                              ram_index_o,
  output llc_tag_pkg::tag_entry_t                          ram_wdata_o,
  input  llc_tag_pkg::tag_entry_t [llc_tag_pkg::NumWays-1:0] ram_rdata_i,
  input  llc_tag_pkg::way_ind_t                            ram_rvalid_i,
  output logic                                             victim_req_o,
  output llc_tag_pkg::way_ind_t                            eligible_o,
  output llc_tag_pkg::way_ind_t                            entry_valid_o,
  input  llc_tag_pkg::way_ind_t                            victim_way_i,
  output llc_tag_pkg::way_ind_t                            rsp_way_o,
  output logic                                             rsp_hit_o,
  output logic                                             rsp_evict_o,
  output llc_tag_pkg::tag_t                                rsp_evict_tag_o,
  output logic                                             rsp_valid_o,
  input  logic                                             rsp_ready_i
);
  import llc_tag_pkg::*;

  ctrl_state_e state_q, state_d;

  // Registered request
  op_t      op_q;
  index_t   index_q;
  tag_t     tag_q;
  logic     dirty_q;
  way_ind_t way_q;

  // Read entries and victim held while waiting in Respond
  tag_entry_t [NumWays-1:0] entry_q;
  way_ind_t                 victim_q;

  // Entries and victim in use this cycle
  tag_entry_t [NumWays-1:0] entry;
  way_ind_t                 victim;
  way_ind_t                 hit;
  logic                     any_hit;
  // Way the response refers to and its entry
  way_ind_t                 sel;
  tag_entry_t               sel_entry;

  logic accept;
  logic rd_done;
  logic data_ok;
  logic handover;

  assign req_ready_o = (state_q == Idle);
  assign accept      = req_ready_o && req_valid_i;
  // Read data arrives in Read, one pulse per read
  assign rd_done     = (state_q == Read) && (|ram_rvalid_i);
  assign data_ok     = rd_done || (state_q == Respond);
  assign handover    = rsp_valid_o && rsp_ready_i;

  // Live read data in Read, captured copy in Respond
  assign entry  = (state_q == Respond) ? entry_q : ram_rdata_i;
  assign victim = (state_q == Respond) ? victim_q : victim_way_i;

  // Hit means enabled and valid and equal tag
  always_comb begin
    for (int i = 0; i < NumWays; i++) begin
      entry_valid_o[i] = entry[i][EntryValidBit];
      hit[i] = way_q[i] & entry[i][EntryValidBit] & (entry[i][TagWidth-1:0] == tag_q);
    end
  end

  assign any_hit = (op_q == OpLookup) && (|hit);

  // Locked ways never become victims
  assign eligible_o   = way_q & ~spm_lock_i;
  assign victim_req_o = rd_done && (op_q == OpLookup) && !(|hit);

  // Flush names its way, lookup points at the hit or the victim
  always_comb begin
    if (op_q == OpFlush) begin
      sel = way_q;
    end else if (any_hit) begin
      sel = hit;
    end else begin
      sel = victim;
    end
  end

  // AND-OR mux, an empty selection yields a zero entry
  always_comb begin
    sel_entry = '0;
    for (int i = 0; i < NumWays; i++) begin
      if (sel[i]) begin
        sel_entry = sel_entry | entry[i];
      end
    end
  end

  // Response fields
  assign rsp_valid_o     = data_ok;
  assign rsp_way_o       = sel;
  assign rsp_hit_o       = any_hit;
  assign rsp_evict_o     = !any_hit && sel_entry[EntryValidBit] && sel_entry[EntryDirtyBit];
  assign rsp_evict_tag_o = rsp_evict_o ? sel_entry[TagWidth-1:0] : '0;

  // Way accesses: read of all ways on accept, write-back on hand-over
  always_comb begin
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = index_q;
    ram_wdata_o = '0;
    if (accept) begin
      ram_req_o   = '1;
      ram_index_o = req_index_i;
    end else if (handover) begin
      if (op_q == OpFlush) begin
        // Flushed entry goes back to all zero
        ram_we_o = way_q;
      end else if (any_hit) begin
        // Only a clean line hit by a dirty request needs a write
        if (dirty_q && !sel_entry[EntryDirtyBit]) begin
          ram_we_o = hit;
        end
        ram_wdata_o[EntryValidBit]  = 1'b1;
        ram_wdata_o[EntryDirtyBit]  = 1'b1;
        ram_wdata_o[TagWidth-1:0]   = tag_q;
      end else begin
        // New tag into the victim, nothing if no way was eligible
        ram_we_o = victim;
        ram_wdata_o[EntryValidBit]  = 1'b1;
        ram_wdata_o[EntryDirtyBit]  = dirty_q;
        ram_wdata_o[TagWidth-1:0]   = tag_q;
      end
      ram_req_o = ram_we_o;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (accept) begin
          state_d = Read;
        end
      end
      Read: begin
        if (rd_done) begin
          state_d = handover ? Idle : Respond;
        end
      end
      Respond: begin
        if (handover) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= req_op_i;
      index_q <= req_index_i;
      tag_q   <= req_tag_i;
      dirty_q <= req_dirty_i;
      way_q   <= req_way_i;
    end
  end

  // Keep entries and victim for a stalled response
  always_ff @(posedge clk_i) begin
    if (rd_done) begin
      entry_q  <= ram_rdata_i;
      victim_q <= victim_way_i;
    end
  end

endmodule

// ==== src/victim_select.sv ====
// Victim way choice, lowest free eligible way first, else round robin over eligible ways
`timescale 1ns/1ps

module victim_select (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_i,
  input  llc_tag_pkg::way_ind_t eligible_i,
  input  llc_tag_pkg::way_ind_t valid_i,
  output llc_tag_pkg::way_ind_t way_o
);
  import llc_tag_pkg::*;

  // Round-robin pointer
  way_bin_t ptr_q, ptr_d;
  // Eligible ways without a valid entry
  way_ind_t free_ways;
  way_ind_t free_way;
  // Result of the round-robin search
  way_bin_t rr_bin;
  logic     rr_found;
  way_bin_t idx;

  assign free_ways = eligible_i & ~valid_i;

  // Lowest-index free way, scanning downwards so the lowest wins
  always_comb begin
    free_way = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (free_ways[i]) begin
        free_way    = '0;
        free_way[i] = 1'b1;
      end
    end
  end

  // First eligible way at or above the pointer, with wrap-around
  always_comb begin
    rr_found = 1'b0;
    rr_bin   = '0;
    idx      = '0;
    for (int k = 0; k < NumWays; k++) begin
      idx = way_bin_t'((int'(ptr_q) + k) % NumWays);
      if (!rr_found && eligible_i[idx]) begin
        rr_found = 1'b1;
        rr_bin   = idx;
      end
    end
  end

  // Free way takes priority and leaves the pointer alone
  always_comb begin
    way_o = '0;
    ptr_d = ptr_q;
    if (|free_ways) begin
      way_o = free_way;
    end else if (rr_found) begin
      way_o[rr_bin] = 1'b1;
      if (req_i) begin
        ptr_d = way_bin_t'((int'(rr_bin) + 1) % NumWays);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

// ==== src/tag_way_ram.sv ====
// Tag way storage with fixed read latency and a read-valid delay line
`timescale 1ns/1ps

module tag_way_ram (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  llc_tag_pkg::index_t     index_i,
  input  llc_tag_pkg::tag_entry_t wdata_i,
  output llc_tag_pkg::tag_entry_t rdata_o,
  output logic                    rvalid_o
);
  import llc_tag_pkg::*;

  // Tag and dirty bits per set
  logic [EntryDirtyBit:0]     mem_q [NumSets];
  // Valid bit per set, cleared by reset
  logic [NumSets-1:0]         valid_q;
  // One pipeline stage per cycle of read latency
  tag_entry_t                 rdata_pipe_q [TagMacroLatency];
  logic [TagMacroLatency-1:0] rvalid_pipe_q;
  tag_entry_t                 rd_entry;
  logic                       rd_en;

  assign rd_en = req_i & ~we_i;

  // Read entry assembled from payload and valid bit
  always_comb begin
    rd_entry                  = '0;
    rd_entry[EntryDirtyBit:0] = mem_q[index_i];
    rd_entry[EntryValidBit]   = valid_q[index_i];
  end

  // Valid bits clear on reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (req_i && we_i) begin
      valid_q[index_i] <= wdata_i[EntryValidBit];
    end
  end

  // Tag and dirty payload
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[index_i] <= wdata_i[EntryDirtyBit:0];
    end
  end

  // First stage loads only on a read and holds otherwise
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_pipe_q[0] <= rd_entry;
    end
    for (int i = 1; i < TagMacroLatency; i++) begin
      rdata_pipe_q[i] <= rdata_pipe_q[i-1];
    end
  end

  // Read-valid token follows the data through the pipeline
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_pipe_q <= '0;
    end else begin
      rvalid_pipe_q[0] <= rd_en;
      for (int i = 1; i < TagMacroLatency; i++) begin
        rvalid_pipe_q[i] <= rvalid_pipe_q[i-1];
      end
    end
  end

  assign rdata_o  = rdata_pipe_q[TagMacroLatency-1];
  assign rvalid_o = rvalid_pipe_q[TagMacroLatency-1];

endmodule

// ==== src/llc_tag_pkg.sv ====
// LLC tag store package with sizes, vector types, operation codes and entry layout
package llc_tag_pkg;

  // Cache geometry
  localparam int unsigned NumWays    = 4;
  localparam int unsigned IndexWidth = 4;
  localparam int unsigned TagWidth   = 8;
  // Number of sets held by each way
  localparam int unsigned NumSets    = 2 ** IndexWidth;

  // Read latency of one tag way in cycles
  localparam int unsigned TagMacroLatency = 1;

  // Stored entry is tag plus valid and dirty
  localparam int unsigned EntryWidth = TagWidth + 2;

  // Bit positions inside a stored entry, tag sits in the low bits
  localparam int unsigned EntryDirtyBit = TagWidth;
  localparam int unsigned EntryValidBit = TagWidth + 1;

  // One bit per way
  typedef logic [NumWays-1:0]         way_ind_t;
  // Set index
  typedef logic [IndexWidth-1:0]      index_t;
  // Stored and requested tag
  typedef logic [TagWidth-1:0]        tag_t;
  // Binary way number
  typedef logic [$clog2(NumWays)-1:0] way_bin_t;
  // Full entry as held in a way
  typedef logic [EntryWidth-1:0]      tag_entry_t;
  // Operation code
  typedef logic [0:0]                 op_t;

  // Supported operations
  localparam op_t OpLookup = 1'b0;
  localparam op_t OpFlush  = 1'b1;

  // Controller states
  typedef enum logic [1:0] {
    Idle,
    Read,
    Respond
  } ctrl_state_e;

endpackage
